/* bench/crossing_golden.txt */
// 01 frame: dirs (left right up down, driven in this frame) player_x player_y car_x0 car_x1 car_x2
// 02 game: colour_sel outcome (01 crushed, 02 won) elapsed 00 00 00
02 6 01 08 00 00 00
01 2 0e 14 00 08 10
01 2 0e 12 01 0a 13
01 2 0e 10 02 0c 16
01 2 0e 0e 03 0e 19
01 2 0e 0c 04 10 1c
01 0 0e 0a 05 12 02
01 0 0e 0a 06 14 05
01 0 0e 0a 07 16 08
01 0 0e 0a 08 18 0b
02 5 02 0b 00 00 00
01 9 0e 14 00 08 10
01 2 0c 14 01 0a 13
01 2 0c 12 02 0c 16
01 2 0c 10 03 0e 19
01 2 0c 0e 04 10 1c
01 2 0c 0c 05 12 02
01 2 0c 0a 06 14 05
01 2 0c 08 07 16 08
01 6 0c 06 08 18 0b
01 6 0e 04 09 1a 0e
01 2 10 02 0a 1c 11
01 0 10 00 0b 01 14

/* compile.f */
source/video_pkg.sv
source/game_pkg.sv
source/player_input.sv
source/traffic.sv
source/game_sequencer.sv
source/sprite_raster.sv
source/crossing_game.sv
bench/crossing_game_checker.sv
bench/tb_crossing_game.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= tb_crossing_game
FILELIST ?= compile.f
LOG ?= sim.log
RUNFLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_crossing_game.sv */
`timescale 1ns/1ps

module tb_crossing_game
	import video_pkg::*;
	import game_pkg::*;
();

	localparam int screen_w = 32;
	localparam int screen_h = 24;
	localparam int clear_pixels = screen_w * screen_h;
	localparam int frame_pixels = clear_pixels + 4 * 16;
	localparam int max_lines = 32;
	localparam int words = 7 * max_lines;

	logic clock;
	logic resetn;
	logic start;
	logic left;
	logic right;
	logic up;
	logic down;
	colour_t player_colour_sel;
	coord_x_t x;
	coord_y_t y;
	colour_t colour;
	logic plot;
	logic crushed;
	logic won;
	logic [9:0] elapsed;

	logic [7:0] golden [words];
	coord_x_t px_x [frame_pixels];
	coord_y_t px_y [frame_pixels];
	colour_t px_c [frame_pixels];
	colour_t frame_buf [clear_pixels];
	int value_errors;
	int other_errors;
	int cycles;
	int cycle_limit;

	crossing_game #(.screen_w(screen_w), .screen_h(screen_h)) dut (
		.clock(clock), .resetn(resetn), .start(start),
		.left(left), .right(right), .up(up), .down(down),
		.player_colour_sel(player_colour_sel),
		.x(x), .y(y), .colour(colour), .plot(plot),
		.crushed(crushed), .won(won), .elapsed(elapsed)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the frame loop stopped making progress", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic x_equal(input string name, input coord_x_t got, input coord_x_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic y_equal(input string name, input coord_y_t got, input coord_y_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic colour_equal(input string name, input colour_t got, input colour_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic flag_equal(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic count_equal(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// collect one frame of pixels, sampled away from the rising edge
	task automatic capture_frame(input logic [3:0] dirs, output bit ended);
		int n;
		n = 0;
		ended = 1'b0;
		while (n < frame_pixels && !ended) begin
			@(negedge clock);
			if (crushed || won) begin
				$display("game ended at %0t before the frame was complete", $time);
				other_errors++;
				ended = 1'b1;
			end else if (plot) begin
				px_x[n] = x;
				px_y[n] = y;
				px_c[n] = colour;
				frame_buf[int'(y) * screen_w + int'(x)] = colour;
				// directions for the next update, set up during the clear pass
				if (n == 0)
					{left, right, up, down} = dirs;
				n++;
			end
		end
	endtask

	task automatic verify_block(input int base, input coord_x_t ox, input coord_y_t oy,
		input colour_t c, input string what, input bit in_buffer);
		int col;
		int row;
		for (int i = 0; i < sprite_size * sprite_size; i++) begin
			col = i % sprite_size;
			row = i / sprite_size;
			x_equal({what, " x"}, px_x[base + i], ox + coord_x_t'(col));
			y_equal({what, " y"}, px_y[base + i], oy + coord_y_t'(row));
			colour_equal({what, " colour"}, px_c[base + i], c);
			if (in_buffer)
				colour_equal({what, " in frame buffer"},
					frame_buf[(int'(oy) + row) * screen_w + int'(ox) + col], c);
		end
	endtask

	task automatic verify_frame(input int b, input colour_t pcol);
		for (int i = 0; i < clear_pixels; i++) begin
			x_equal("clear x", px_x[i], coord_x_t'(i % screen_w));
			y_equal("clear y", px_y[i], coord_y_t'(i / screen_w));
			colour_equal("clear colour", px_c[i], colour_black);
		end
		// lane k sits one sprite per index below the top, colour k + 1
		for (int k = 0; k < 3; k++)
			verify_block(clear_pixels + 16 * k, coord_x_t'(golden[b + 4 + k]),
				coord_y_t'(sprite_size * (k + 1)), colour_t'(k + 1),
				$sformatf("car%0d", k), 1'b0);
		verify_block(clear_pixels + 48, coord_x_t'(golden[b + 2]), coord_y_t'(golden[b + 3]),
			pcol, "player", 1'b1);
	endtask

	task automatic await_game_end(input logic [7:0] outcome, input logic [9:0] exp_elapsed);
		bit quiet;
		quiet = 1'b1;
		@(negedge clock);
		while (!(crushed || won) && !plot)
			@(negedge clock);
		if (plot) begin
			$display("pixels drawn at %0t after the last frame, the game did not end", $time);
			other_errors++;
		end
		flag_equal("crushed", crushed, outcome == 8'h01);
		flag_equal("won", won, outcome == 8'h02);
		count_equal("elapsed at end", elapsed, exp_elapsed);
		repeat (20) begin
			@(negedge clock);
			if (plot)
				quiet = 1'b0;
		end
		if (!quiet) begin
			$display("pixels drawn at %0t while the game was over", $time);
			other_errors++;
		end
	endtask

	initial begin
		int line;
		int b;
		int n_frames;
		int frame_no;
		bit ended;
		colour_t game_colour;
		logic [7:0] outcome;
		logic [9:0] exp_elapsed;
		clock = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		{left, right, up, down} = 4'b0000;
		player_colour_sel = colour_black;
		value_errors = 0;
		other_errors = 0;
		cycles = 0;
		cycle_limit = 0;
		game_colour = colour_black;
		outcome = '0;
		exp_elapsed = '0;
		frame_no = 0;
		for (int i = 0; i < words; i++)
			golden[i] = 8'h00;
		$readmemh("bench/crossing_golden.txt", golden);
		n_frames = 0;
		for (int i = 0; i < max_lines; i++)
			if (golden[7 * i] == 8'h01)
				n_frames++;
		cycle_limit = n_frames * (clear_pixels + 4 * 16 + 20) + 200;

		repeat (3) @(posedge clock);
		@(negedge clock);
		resetn = 1'b1;
		flag_equal("plot after reset", plot, 1'b0);
		flag_equal("crushed after reset", crushed, 1'b0);
		flag_equal("won after reset", won, 1'b0);
		count_equal("elapsed after reset", elapsed, 10'd0);

		line = 0;
		while (line < max_lines && golden[7 * line] != 8'h00) begin
			b = 7 * line;
			if (golden[b] == 8'h02) begin
				game_colour = colour_t'(golden[b + 1]);
				outcome = golden[b + 2];
				exp_elapsed = 10'(golden[b + 3]);
				frame_no = 0;
				player_colour_sel = game_colour;
				@(negedge clock);
				start = 1'b1;
				@(negedge clock);
				start = 1'b0;
				count_equal("elapsed after start", elapsed, 10'd0);
				flag_equal("crushed after start", crushed, 1'b0);
				flag_equal("won after start", won, 1'b0);
			end else begin
				capture_frame(golden[b + 1][3:0], ended);
				if (!ended) begin
					count_equal("elapsed in frame", elapsed, 10'(frame_no));
					verify_frame(b, game_colour);
				end
				frame_no++;
				if (line + 1 >= max_lines || golden[b + 7] != 8'h01)
					await_game_end(outcome, exp_elapsed);
			end
			line++;
		end

		$display("errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, dut.u_checker.failures);
		if (value_errors == 0 && other_errors == 0 && dut.u_checker.failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* bench/crossing_game_checker.sv */
`timescale 1ns/1ps

module crossing_game_checker
	import video_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input coord_x_t x,
	input coord_y_t y,
	input logic plot,
	input logic crushed,
	input logic won,
	input logic [9:0] elapsed
);

	int unsigned failures = 0;

	// the raster is idle from the first clock of reset
	plot_in_reset: assert property (@(posedge clock) !resetn |=> !plot) else begin
		failures++;
		$error("plot high while in reset");
	end

	pixel_on_screen: assert property (@(posedge clock) disable iff (!resetn)
		plot |-> (int'(x) < screen_w && int'(y) < screen_h)) else begin
		failures++;
		$error("pixel outside the screen");
	end

	one_outcome: assert property (@(posedge clock) disable iff (!resetn)
		!(crushed && won)) else begin
		failures++;
		$error("crushed and won both high");
	end

	// score is frozen once the game is over
	score_frozen: assert property (@(posedge clock) disable iff (!resetn)
		(crushed || won) |-> $stable(elapsed)) else begin
		failures++;
		$error("elapsed changed after the game ended");
	end

endmodule

bind crossing_game crossing_game_checker #(
	.screen_w(screen_w),
	.screen_h(screen_h)
) u_checker (
	.clock(clock),
	.resetn(resetn),
	.x(x),
	.y(y),
	.plot(plot),
	.crushed(crushed),
	.won(won),
	.elapsed(elapsed)
);

/* source/crossing_game.sv */
`timescale 1ns/1ps

module crossing_game
	import video_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	input colour_t player_colour_sel,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t colour,
	output logic plot,
	output logic crushed,
	output logic won,
	output logic [9:0] elapsed
);

	logic restart;
	logic advance;
	logic draw;
	logic done;
	coord_x_t player_x;
	coord_y_t player_y;
	colour_t player_colour;
	coord_x_t car_x0;
	coord_x_t car_x1;
	coord_x_t car_x2;
	coord_x_t origin_x;
	coord_y_t origin_y;
	coord_x_t width;
	coord_y_t height;
	colour_t fill;

	player_input #(.screen_w(screen_w), .screen_h(screen_h)) u_player (
		.clock(clock), .resetn(resetn), .restart(restart), .advance(advance),
		.left(left), .right(right), .up(up), .down(down),
		.player_colour_sel(player_colour_sel),
		.player_x(player_x), .player_y(player_y), .player_colour(player_colour)
	);

	traffic #(.screen_w(screen_w), .screen_h(screen_h)) u_traffic (
		.clock(clock), .resetn(resetn), .restart(restart), .advance(advance),
		.car_x0(car_x0), .car_x1(car_x1), .car_x2(car_x2)
	);

	game_sequencer #(.screen_w(screen_w), .screen_h(screen_h)) u_sequencer (
		.clock(clock), .resetn(resetn), .start(start), .done(done),
		.player_x(player_x), .car_x0(car_x0), .car_x1(car_x1), .car_x2(car_x2),
		.player_y(player_y), .player_colour(player_colour),
		.restart(restart), .advance(advance), .draw(draw),
		.origin_x(origin_x), .origin_y(origin_y), .width(width), .height(height),
		.fill(fill), .crushed(crushed), .won(won), .elapsed(elapsed)
	);

	// single pixel source for the whole frame
	sprite_raster #(.screen_w(screen_w), .screen_h(screen_h)) u_raster (
		.clock(clock), .resetn(resetn), .draw(draw),
		.origin_x(origin_x), .origin_y(origin_y), .width(width), .height(height),
		.fill(fill), .x(x), .y(y), .colour(colour), .plot(plot), .done(done)
	);

endmodule

/* source/sprite_raster.sv */
`timescale 1ns/1ps

module sprite_raster
	import video_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input logic draw,
	input coord_x_t origin_x,
	input coord_y_t origin_y,
	input coord_x_t width,
	input coord_y_t height,
	input colour_t fill,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t colour,
	output logic plot,
	output logic done
);

	coord_x_t ox_q;
	coord_y_t oy_q;
	coord_x_t w_q;
	coord_y_t h_q;
	coord_x_t col;
	coord_y_t row;
	coord_x_t clip_w;
	coord_y_t clip_h;
	coord_x_t next_col;
	coord_y_t next_row;
	logic wrap;

	always_comb begin
		// trim anything past the right or bottom edge
		if (int'(origin_x) + int'(width) > screen_w)
			clip_w = coord_x_t'(screen_w - int'(origin_x));
		else
			clip_w = width;
		if (int'(origin_y) + int'(height) > screen_h)
			clip_h = coord_y_t'(screen_h - int'(origin_y));
		else
			clip_h = height;
		wrap = (col == w_q - coord_x_t'(1));
		next_col = wrap ? '0 : col + coord_x_t'(1);
		next_row = wrap ? row + coord_y_t'(1) : row;
	end

	// plot doubles as the busy flag, done marks the last pixel
	always_ff @(posedge clock) begin
		if (!resetn) begin
			plot <= 1'b0;
			done <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (draw) begin
			plot <= 1'b1;
			done <= (clip_w == coord_x_t'(1)) && (clip_h == coord_y_t'(1));
			col <= '0;
			row <= '0;
		end else if (plot && !done) begin
			plot <= 1'b1;
			done <= (next_col == w_q - coord_x_t'(1)) && (next_row == h_q - coord_y_t'(1));
			col <= next_col;
			row <= next_row;
		end else begin
			plot <= 1'b0;
			done <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (draw) begin
			ox_q <= origin_x;
			oy_q <= origin_y;
			w_q <= clip_w;
			h_q <= clip_h;
			x <= origin_x;
			y <= origin_y;
			colour <= fill;
		end else if (plot && !done) begin
			x <= ox_q + next_col;
			y <= oy_q + next_row;
		end
	end

endmodule

/* source/game_sequencer.sv */
`timescale 1ns/1ps

module game_sequencer
	import video_pkg::*;
	import game_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic done,
	input coord_x_t player_x,
	input coord_x_t car_x0,
	input coord_x_t car_x1,
	input coord_x_t car_x2,
	input coord_y_t player_y,
	input colour_t player_colour,
	output logic restart,
	output logic advance,
	output logic draw,
	output coord_x_t origin_x,
	output coord_y_t origin_y,
	output coord_x_t width,
	output coord_y_t height,
	output colour_t fill,
	output logic crushed,
	output logic won,
	output logic [9:0] elapsed
);

	seq_state_t state;
	car_index_t car_idx;
	coord_x_t car_x [num_cars];
	logic hit;

	function automatic int gap(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	assign car_x[0] = car_x0;
	assign car_x[1] = car_x1;
	assign car_x[2] = car_x2;

	// overlap test of the player square against every car square
	always_comb begin
		hit = 1'b0;
		for (int k = 0; k < num_cars; k++) begin
			if (gap(int'(player_x), int'(car_x[k])) < sprite_size &&
			    gap(int'(player_y), int'(car_lane_y[k])) < sprite_size)
				hit = 1'b1;
		end
	end

	// rectangle for the current draw step
	always_comb begin
		origin_x = '0;
		origin_y = '0;
		width = coord_x_t'(sprite_size);
		height = coord_y_t'(sprite_size);
		fill = colour_black;
		case (state)
			seq_clear: begin
				width = coord_x_t'(screen_w);
				height = coord_y_t'(screen_h);
			end
			seq_draw_car: begin
				origin_x = car_x[car_idx];
				origin_y = car_lane_y[car_idx];
				fill = car_colour[car_idx];
			end
			seq_draw_player: begin
				origin_x = player_x;
				origin_y = player_y;
				fill = player_colour;
			end
			default: begin
			end
		endcase
	end

	// pulses are raised on the edge that enters the next state
	always_ff @(posedge clock) begin
		if (!resetn) begin
			state <= seq_idle;
			car_idx <= '0;
			restart <= 1'b0;
			advance <= 1'b0;
			draw <= 1'b0;
			crushed <= 1'b0;
			won <= 1'b0;
			elapsed <= '0;
		end else begin
			restart <= 1'b0;
			advance <= 1'b0;
			draw <= 1'b0;
			case (state)
				seq_idle, seq_over: begin
					// first frame of a game goes straight to clear
					if (start) begin
						crushed <= 1'b0;
						won <= 1'b0;
						elapsed <= '0;
						restart <= 1'b1;
						draw <= 1'b1;
						state <= seq_clear;
					end
				end
				seq_update: begin
					draw <= 1'b1;
					state <= seq_clear;
				end
				seq_clear: begin
					if (done) begin
						car_idx <= '0;
						draw <= 1'b1;
						state <= seq_draw_car;
					end
				end
				seq_draw_car: begin
					if (done) begin
						draw <= 1'b1;
						if (car_idx == car_index_t'(num_cars - 1))
							state <= seq_draw_player;
						else
							car_idx <= car_idx + car_index_t'(1);
					end
				end
				seq_draw_player: begin
					if (done)
						state <= seq_check;
				end
				seq_check: begin
					if (hit) begin
						crushed <= 1'b1;
						state <= seq_over;
					end else if (player_y == '0) begin
						won <= 1'b1;
						state <= seq_over;
					end else begin
						elapsed <= elapsed + 10'd1;
						advance <= 1'b1;
						state <= seq_update;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

endmodule

/* source/traffic.sv */
`timescale 1ns/1ps

module traffic
	import video_pkg::*;
	import game_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input logic restart,
	input logic advance,
	output coord_x_t car_x0,
	output coord_x_t car_x1,
	output coord_x_t car_x2
);

	localparam int max_x = screen_w - sprite_size;

	// lanes plus the goal row and the start row must fit
	if (screen_h < sprite_size * (num_cars + 2) || screen_w < 2 * sprite_size) begin : g_size_check
		$error("screen is too small for the car lanes");
	end

	coord_x_t car_x [num_cars];
	coord_x_t next_x [num_cars];

	// step right, wrap back to the left edge past the last column
	always_comb begin
		for (int k = 0; k < num_cars; k++) begin
			if (int'(car_x[k]) + int'(car_speed[k]) > max_x)
				next_x[k] = coord_x_t'(int'(car_x[k]) + int'(car_speed[k]) - (max_x + 1));
			else
				next_x[k] = car_x[k] + car_speed[k];
		end
	end

	always_ff @(posedge clock) begin
		if (!resetn || restart) begin
			for (int k = 0; k < num_cars; k++)
				car_x[k] <= car_start_x[k];
		end else if (advance) begin
			for (int k = 0; k < num_cars; k++)
				car_x[k] <= next_x[k];
		end
	end

	assign car_x0 = car_x[0];
	assign car_x1 = car_x[1];
	assign car_x2 = car_x[2];

endmodule

/* source/player_input.sv */
`timescale 1ns/1ps

module player_input
	import video_pkg::*;
	import game_pkg::*;
#(
	parameter int screen_w = 160,
	parameter int screen_h = 120
) (
	input logic clock,
	input logic resetn,
	input logic restart,
	input logic advance,
	input logic left,
	input logic right,
	input logic up,
	input logic down,
	input colour_t player_colour_sel,
	output coord_x_t player_x,
	output coord_y_t player_y,
	output colour_t player_colour
);

	localparam int max_x = screen_w - sprite_size;
	localparam int max_y = screen_h - sprite_size;
	localparam coord_x_t start_x = coord_x_t'(max_x / 2);
	localparam coord_y_t start_y = coord_y_t'(max_y);

	int next_x;
	int next_y;

	// net step per axis, then clamp to the screen
	always_comb begin
		next_x = int'(player_x);
		next_y = int'(player_y);
		if (right)
			next_x = next_x + player_step;
		if (left)
			next_x = next_x - player_step;
		if (down)
			next_y = next_y + player_step;
		// up moves toward the goal row
		if (up)
			next_y = next_y - player_step;
		if (next_x < 0)
			next_x = 0;
		else if (next_x > max_x)
			next_x = max_x;
		if (next_y < 0)
			next_y = 0;
		else if (next_y > max_y)
			next_y = max_y;
	end

	always_ff @(posedge clock) begin
		if (!resetn) begin
			player_x <= start_x;
			player_y <= start_y;
		end else if (restart) begin
			player_x <= start_x;
			player_y <= start_y;
		end else if (advance) begin
			player_x <= coord_x_t'(next_x);
			player_y <= coord_y_t'(next_y);
		end
	end

	// colour is picked once per game
	always_ff @(posedge clock) begin
		if (restart)
			player_colour <= player_colour_sel;
	end

endmodule

/* source/game_pkg.sv */
package game_pkg;

	import video_pkg::*;

	// cars and player share one square sprite
	localparam int sprite_size = 4;
	localparam int player_step = 2;

	localparam int num_cars = 3;
	typedef logic [1:0] car_index_t;

	// car table, index 0 in the low slot
	// lanes sit one sprite apart below the goal row
	localparam coord_y_t [num_cars-1:0] car_lane_y = {7'd12, 7'd8, 7'd4};
	localparam coord_x_t [num_cars-1:0] car_start_x = {8'd16, 8'd8, 8'd0};
	localparam coord_x_t [num_cars-1:0] car_speed = {8'd3, 8'd2, 8'd1};
	// blue, green, cyan
	localparam colour_t [num_cars-1:0] car_colour = {3'b011, 3'b010, 3'b001};

	typedef enum logic [2:0] {
		seq_idle,
		seq_update,
		seq_clear,
		seq_draw_car,
		seq_draw_player,
		seq_check,
		seq_over
	} seq_state_t;

endpackage

/* source/video_pkg.sv */
package video_pkg;

	// pixel coordinates on the 160x120 grid
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// one bit each for red, green and blue
	typedef logic [2:0] colour_t;

	localparam colour_t colour_black = 3'b000;

endpackage
